/* design/sf_clock_pkg.sv */
// clock divider width, pixel clock tap positions and enable period
`default_nettype none

package sf_clock_pkg;

   // ==================================================
   // 48 MHz divider
   // ==================================================

   // free-running counter, only the low bits are tapped
   localparam int DIV_W = 4;

   // bit 1 toggles every 2 clk: 48 / 4 = 12 MHz
   localparam int PIX12_TAP = 1;

   // bit 2 toggles every 4 clk: 48 / 8 = 6 MHz
   localparam int PIX6_TAP = 2;

   // clk cycles between two 6 MHz enable pulses
   localparam int PIX6_PERIOD = 8;

endpackage

`default_nettype wire

/* design/sf_logic_pkg.sv */
// data widths, shift mode enum and packed control structs for the logic units
`default_nettype none

package sf_logic_pkg;

   localparam int BYTE_W = 8;
   // one ls283 / ls85 stage
   localparam int NIB_W = 4;
   // ls148 code width
   localparam int SEL3_W = 3;

   // ==================================================
   // ls194 select pins S1 S0
   // ==================================================
   typedef enum logic [1:0] {
      SHIFT_HOLD = 2'b00,
      SHIFT_UP   = 2'b01,
      SHIFT_DOWN = 2'b10,
      SHIFT_LOAD = 2'b11
   } shift_mode_e;

   typedef struct packed {
      shift_mode_e       mode;
      logic              ser_up;
      logic              ser_down;
      logic [BYTE_W-1:0] par;
   } shift_ctrl_t;

   // ==================================================
   // decoder and comparator buses
   // ==================================================
   typedef struct packed {
      logic              e3;
      logic              ne1;
      logic              ne2;
      logic [SEL3_W-1:0] sel;
   } dec8_in_t;

   // one half of the ls139
   typedef struct packed {
      logic       ne;
      logic [1:0] sel;
   } dec4_lane_t;

   typedef struct packed {
      dec4_lane_t lane_a;
      dec4_lane_t lane_b;
   } dec4x2_in_t;

   // ls85 cascade inputs and outputs share this layout
   typedef struct packed {
      logic a_lt_b;
      logic a_eq_b;
      logic a_gt_b;
   } cascade_t;

   typedef struct packed {
      logic [SEL3_W-1:0] code_n;
      logic              gs_n;
      logic              eo_n;
   } prio_out_t;

endpackage

`default_nettype wire

/* design/sf_clock_enable.sv */
// 48 MHz divider counter, 12 and 6 MHz pixel clocks and 6 MHz enable pulse
`default_nettype none

module sf_clock_enable
   import sf_clock_pkg::*;
(
   input  logic clk,
   input  logic CR,
   output logic pix12_o,
   output logic pix6_o,
   output logic pix6_cen_o
);

   logic [DIV_W-1:0] div_cnt;
   // 6 MHz bit one clk late, for edge detection
   logic             pix6_q;

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         div_cnt    <= '0;
         pix6_q     <= 1'b0;
         pix6_cen_o <= 1'b0;
      end
      else
      begin
         div_cnt    <= div_cnt + DIV_W'(1);
         pix6_q     <= div_cnt[PIX6_TAP];
         // rising edge of the 6 MHz clock
         pix6_cen_o <= div_cnt[PIX6_TAP] & ~pix6_q;
      end
   end

   assign pix12_o = div_cnt[PIX12_TAP];
   assign pix6_o  = div_cnt[PIX6_TAP];

   // ==================================================
   // checks
   // ==================================================

   // single-cycle pulse, then quiet until the next 6 MHz period
   a_cen_spacing : assert property (
      @(posedge clk) disable iff (!CR)
      pix6_cen_o |=> !pix6_cen_o [* PIX6_PERIOD - 1] ##1 pix6_cen_o
   );

endmodule

`default_nettype wire

/* design/sf_pixel_shifter.sv */
// 8-bit universal shift register with pixel clock enable (ls194 pair)
`default_nettype none

module sf_pixel_shifter
   import sf_logic_pkg::*;
(
   input  logic              clk,
   input  logic              CR,
   input  logic              cen_i,
   input  shift_ctrl_t       ctrl_i,
   output logic [BYTE_W-1:0] pixel_o
);

   // ==================================================
   // shift register
   // ==================================================
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         pixel_o <= '0;
      end
      else if (cen_i)
      begin
         case (ctrl_i.mode)
            // towards the msb, serial bit enters at bit 0
            SHIFT_UP:
               pixel_o <= {pixel_o[BYTE_W-2:0], ctrl_i.ser_up};
            // towards the lsb, serial bit enters at bit 7
            SHIFT_DOWN:
               pixel_o <= {ctrl_i.ser_down, pixel_o[BYTE_W-1:1]};
            SHIFT_LOAD:
               pixel_o <= ctrl_i.par;
            default:
               pixel_o <= pixel_o;
         endcase
      end
   end

   // ==================================================
   // checks
   // ==================================================

   // nothing moves between pixel enables, whatever the mode
   a_hold_without_cen : assert property (
      @(posedge clk) disable iff (!CR)
      !cen_i |=> (pixel_o == $past(pixel_o))
   );

endmodule

`default_nettype wire

/* design/sf_select_decoder.sv */
// active-low 3-to-8 (ls138) and dual 2-to-4 (ls139) chip-select decoders
`default_nettype none

module sf_select_decoder
   import sf_logic_pkg::*;
(
   input  dec8_in_t          dec8_i,
   input  dec4x2_in_t        dec4_i,
   output logic [BYTE_W-1:0] cs8_n_o,
   output logic [NIB_W-1:0]  cs4a_n_o,
   output logic [NIB_W-1:0]  cs4b_n_o
);

   logic dec8_en;

   // one ls139 half, shared by both lanes
   function automatic logic [NIB_W-1:0] decode_lane(input dec4_lane_t lane);
      logic [NIB_W-1:0] onehot;
      onehot = NIB_W'(1) << lane.sel;
      if (lane.ne)
         decode_lane = '1;
      else
         decode_lane = ~onehot;
   endfunction

   // ==================================================
   // ls138
   // ==================================================

   // E3 high and both active-low enables low
   assign dec8_en = dec8_i.e3 & ~dec8_i.ne1 & ~dec8_i.ne2;

   assign cs8_n_o = dec8_en ? ~(BYTE_W'(1) << dec8_i.sel) : '1;

   // ==================================================
   // ls139
   // ==================================================
   assign cs4a_n_o = decode_lane(dec4_i.lane_a);
   assign cs4b_n_o = decode_lane(dec4_i.lane_b);

   // two selects low at once would mean a bus fight on the board
   always_comb
   begin
      a_cs8_one_low : assert ($onehot0(~cs8_n_o));
      a_cs4a_one_low : assert ($onehot0(~cs4a_n_o));
      a_cs4b_one_low : assert ($onehot0(~cs4b_n_o));
   end

endmodule

`default_nettype wire

/* design/sf_position_unit.sv */
// 8-bit adder built from two 4-bit stages, and 8-bit cascadable magnitude comparator
`default_nettype none

module sf_position_unit
   import sf_logic_pkg::*;
(
   input  logic [BYTE_W-1:0] add_a_i,
   input  logic [BYTE_W-1:0] add_b_i,
   input  logic              carry_i,
   input  logic [BYTE_W-1:0] cmp_a_i,
   input  logic [BYTE_W-1:0] cmp_b_i,
   input  cascade_t          cascade_i,
   output logic [BYTE_W-1:0] sum_o,
   output logic              carry_o,
   output cascade_t          cmp_o
);

   logic             carry_mid;
   logic [NIB_W-1:0] sum_lo;
   logic [NIB_W-1:0] sum_hi;

   // one ls283: returns {carry out, sum}
   function automatic logic [NIB_W:0] add_stage(
      input logic [NIB_W-1:0] a,
      input logic [NIB_W-1:0] b,
      input logic             cin
   );
      add_stage = {1'b0, a} + {1'b0, b} + {{NIB_W{1'b0}}, cin};
   endfunction

   // ==================================================
   // adder, low nibble carries into high nibble
   // ==================================================
   assign {carry_mid, sum_lo} = add_stage(add_a_i[NIB_W-1:0], add_b_i[NIB_W-1:0], carry_i);
   assign {carry_o, sum_hi} = add_stage(add_a_i[BYTE_W-1:NIB_W], add_b_i[BYTE_W-1:NIB_W],
                                        carry_mid);
   assign sum_o = {sum_hi, sum_lo};

   // ==================================================
   // comparator
   // ==================================================
   always_comb
   begin
      cmp_o = '0;
      if (cmp_a_i > cmp_b_i)
         cmp_o.a_gt_b = 1'b1;
      else if (cmp_a_i < cmp_b_i)
         cmp_o.a_lt_b = 1'b1;
      else if (cascade_i.a_eq_b)
         cmp_o.a_eq_b = 1'b1;
      else
      begin
         // ls85 cascade rule: mixed inputs pass through,
         // both low gives both high, both high gives both low
         cmp_o.a_gt_b = ~cascade_i.a_lt_b;
         cmp_o.a_lt_b = ~cascade_i.a_gt_b;
      end
   end

endmodule

`default_nettype wire

/* design/sf_priority_encoder.sv */
// 8-to-3 active-low priority encoder with enable in, group select and enable out (ls148)
`default_nettype none

module sf_priority_encoder
   import sf_logic_pkg::*;
(
   input  logic [BYTE_W-1:0] req_n_i,
   input  logic              ei_n_i,
   output prio_out_t         prio_o
);

   logic [SEL3_W-1:0] top_idx;
   logic              any_req;

   // highest-numbered low request wins
   always_comb
   begin
      top_idx = '0;
      any_req = 1'b0;
      for (int i = 0; i < BYTE_W; i++)
      begin
         if (!req_n_i[i])
         begin
            top_idx = SEL3_W'(i);
            any_req = 1'b1;
         end
      end
   end

   always_comb
   begin
      if (ei_n_i)
      begin
         // disabled chip, everything high
         prio_o = '1;
      end
      else
      begin
         prio_o.code_n = ~top_idx;
         prio_o.gs_n   = ~any_req;
         // lets the next encoder in the chain take over
         prio_o.eo_n   = any_req;
      end
   end

endmodule

`default_nettype wire

/* design/sf_logic_top.sv */
// top level connecting clock enables, pixel shifter, decoders, position unit and encoder
`default_nettype none

module sf_logic_top
   import sf_logic_pkg::*;
(
   input  logic              clk,
   input  logic              CR,
   input  shift_ctrl_t       shift_ctrl_i,
   input  dec8_in_t          dec8_i,
   input  dec4x2_in_t        dec4_i,
   input  logic [BYTE_W-1:0] add_a_i,
   input  logic [BYTE_W-1:0] add_b_i,
   input  logic              carry_i,
   input  logic [BYTE_W-1:0] cmp_a_i,
   input  logic [BYTE_W-1:0] cmp_b_i,
   input  cascade_t          cascade_i,
   input  logic [BYTE_W-1:0] prio_req_n_i,
   input  logic              prio_ei_n_i,
   output logic              pix12_o,
   output logic              pix6_o,
   output logic              pix6_cen_o,
   output logic [BYTE_W-1:0] pixel_o,
   output logic [BYTE_W-1:0] cs8_n_o,
   output logic [NIB_W-1:0]  cs4a_n_o,
   output logic [NIB_W-1:0]  cs4b_n_o,
   output logic [BYTE_W-1:0] sum_o,
   output logic              carry_o,
   output cascade_t          cmp_o,
   output prio_out_t         prio_o
);

   // ==================================================
   // pixel clock domain
   // ==================================================
   sf_clock_enable sf_clock_enable_inst (
      .clk        (clk),
      .CR         (CR),
      .pix12_o    (pix12_o),
      .pix6_o     (pix6_o),
      .pix6_cen_o (pix6_cen_o)
   );

   sf_pixel_shifter sf_pixel_shifter_inst (
      .clk     (clk),
      .CR      (CR),
      .cen_i   (pix6_cen_o),
      .ctrl_i  (shift_ctrl_i),
      .pixel_o (pixel_o)
   );

   // combinational leaves
   sf_select_decoder sf_select_decoder_inst (
      .dec8_i   (dec8_i),
      .dec4_i   (dec4_i),
      .cs8_n_o  (cs8_n_o),
      .cs4a_n_o (cs4a_n_o),
      .cs4b_n_o (cs4b_n_o)
   );

   sf_position_unit sf_position_unit_inst (
      .add_a_i   (add_a_i),
      .add_b_i   (add_b_i),
      .carry_i   (carry_i),
      .cmp_a_i   (cmp_a_i),
      .cmp_b_i   (cmp_b_i),
      .cascade_i (cascade_i),
      .sum_o     (sum_o),
      .carry_o   (carry_o),
      .cmp_o     (cmp_o)
   );

   sf_priority_encoder sf_priority_encoder_inst (
      .req_n_i (prio_req_n_i),
      .ei_n_i  (prio_ei_n_i),
      .prio_o  (prio_o)
   );

endmodule

`default_nettype wire

/* test/tb_sf_logic_top.sv */
// clock, reset, lfsr stimulus, reference model and checks for the logic top level
`default_nettype none

module tb_sf_logic_top
   import sf_clock_pkg::*, sf_logic_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_CYCLES = 400;
   localparam int PULSE_TIMEOUT = 20;

   logic              clk;
   logic              CR;
   shift_ctrl_t       shift_ctrl_i;
   dec8_in_t          dec8_i;
   dec4x2_in_t        dec4_i;
   logic [BYTE_W-1:0] add_a_i;
   logic [BYTE_W-1:0] add_b_i;
   logic              carry_i;
   logic [BYTE_W-1:0] cmp_a_i;
   logic [BYTE_W-1:0] cmp_b_i;
   cascade_t          cascade_i;
   logic [BYTE_W-1:0] prio_req_n_i;
   logic              prio_ei_n_i;
   logic              pix12_o;
   logic              pix6_o;
   logic              pix6_cen_o;
   logic [BYTE_W-1:0] pixel_o;
   logic [BYTE_W-1:0] cs8_n_o;
   logic [NIB_W-1:0]  cs4a_n_o;
   logic [NIB_W-1:0]  cs4b_n_o;
   logic [BYTE_W-1:0] sum_o;
   logic              carry_o;
   cascade_t          cmp_o;
   prio_out_t         prio_o;

   // model state mirroring divider and shifter
   logic [DIV_W-1:0]  cnt_m;
   logic              q_m;
   logic              cen_m;
   logic [BYTE_W-1:0] pix_m;

   // pulse and toggle history
   logic [1:0]        pix6_hist;
   logic              pix12_prev;
   logic              seen_pulse;
   logic              seen_toggle;
   logic              got_pulse;
   int                last_pulse;
   int                last_toggle;
   int                cyc;
   int                value_errs;
   int                other_errs;
   logic [15:0]       lfsr;

   sf_logic_top sf_logic_top_inst (
      .clk          (clk),
      .CR           (CR),
      .shift_ctrl_i (shift_ctrl_i),
      .dec8_i       (dec8_i),
      .dec4_i       (dec4_i),
      .add_a_i      (add_a_i),
      .add_b_i      (add_b_i),
      .carry_i      (carry_i),
      .cmp_a_i      (cmp_a_i),
      .cmp_b_i      (cmp_b_i),
      .cascade_i    (cascade_i),
      .prio_req_n_i (prio_req_n_i),
      .prio_ei_n_i  (prio_ei_n_i),
      .pix12_o      (pix12_o),
      .pix6_o       (pix6_o),
      .pix6_cen_o   (pix6_cen_o),
      .pixel_o      (pixel_o),
      .cs8_n_o      (cs8_n_o),
      .cs4a_n_o     (cs4a_n_o),
      .cs4b_n_o     (cs4b_n_o),
      .sum_o        (sum_o),
      .carry_o      (carry_o),
      .cmp_o        (cmp_o),
      .prio_o       (prio_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ==================================================
   // stimulus source
   // ==================================================

   // fibonacci lfsr x^16 + x^14 + x^13 + x^11 + 1
   // stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic drive_random();
      logic [31:0]       r;
      dec8_in_t          d8;
      logic [BYTE_W-1:0] ca;
      logic [BYTE_W-1:0] cb;
      logic [BYTE_W-1:0] req;
      r = rand_bits(12);
      shift_ctrl_i <= shift_ctrl_t'(r[11:0]);
      r = rand_bits(6);
      d8 = dec8_in_t'(r[5:0]);
      // mostly enabled so the select path gets exercised
      if (rand_bits(2) != 0)
      begin
         d8.e3  = 1'b1;
         d8.ne1 = 1'b0;
         d8.ne2 = 1'b0;
      end
      dec8_i <= d8;
      r = rand_bits(6);
      dec4_i <= dec4x2_in_t'(r[5:0]);
      r = rand_bits(17);
      add_a_i <= r[16:9];
      add_b_i <= r[8:1];
      carry_i <= r[0];
      r = rand_bits(16);
      ca = r[15:8];
      cb = r[7:0];
      // equal operands one time in four
      if (rand_bits(2) == 0)
         cb = ca;
      cmp_a_i <= ca;
      cmp_b_i <= cb;
      r = rand_bits(3);
      cascade_i <= cascade_t'(r[2:0]);
      r = rand_bits(8);
      req = r[7:0];
      if (rand_bits(3) == 0)
         req = '1;
      prio_req_n_i <= req;
      prio_ei_n_i  <= (rand_bits(2) == 0);
   endtask

   // ==================================================
   // reference model and checks
   // ==================================================

   // runs on the dut's edge while inputs still hold the sampled values
   task automatic update_model();
      logic cen_next;
      if (cen_m)
      begin
         case (shift_ctrl_i.mode)
            SHIFT_UP:   pix_m = {pix_m[BYTE_W-2:0], shift_ctrl_i.ser_up};
            SHIFT_DOWN: pix_m = {shift_ctrl_i.ser_down, pix_m[BYTE_W-1:1]};
            SHIFT_LOAD: pix_m = shift_ctrl_i.par;
            default:    pix_m = pix_m;
         endcase
      end
      cen_next = cnt_m[PIX6_TAP] & ~q_m;
      q_m      = cnt_m[PIX6_TAP];
      cnt_m    = cnt_m + DIV_W'(1);
      cen_m    = cen_next;
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else
      begin
         value_errs++;
         $display("ERR t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond)
      else
      begin
         other_errs++;
         $display("t=%0t %s", $time, what);
      end
   endtask

   task automatic check_outputs();
      logic [BYTE_W-1:0] exp8;
      logic [NIB_W-1:0]  exp4a;
      logic [NIB_W-1:0]  exp4b;
      logic [BYTE_W:0]   exp_add;
      cascade_t          exp_cmp;
      prio_out_t         exp_prio;
      logic              found;
      check_value("pix12_o", 32'(cnt_m[PIX12_TAP]), 32'(pix12_o));
      check_value("pix6_o", 32'(cnt_m[PIX6_TAP]), 32'(pix6_o));
      check_value("pix6_cen_o", 32'(cen_m), 32'(pix6_cen_o));
      check_value("pixel_o", 32'(pix_m), 32'(pixel_o));
      // one low output when enabled and all high otherwise
      exp8 = '1;
      if (dec8_i.e3 && !dec8_i.ne1 && !dec8_i.ne2)
         exp8[dec8_i.sel] = 1'b0;
      exp4a = '1;
      if (!dec4_i.lane_a.ne)
         exp4a[dec4_i.lane_a.sel] = 1'b0;
      exp4b = '1;
      if (!dec4_i.lane_b.ne)
         exp4b[dec4_i.lane_b.sel] = 1'b0;
      check_value("cs8_n_o", 32'(exp8), 32'(cs8_n_o));
      check_value("cs4a_n_o", 32'(exp4a), 32'(cs4a_n_o));
      check_value("cs4b_n_o", 32'(exp4b), 32'(cs4b_n_o));
      exp_add = {1'b0, add_a_i} + {1'b0, add_b_i} + {{BYTE_W{1'b0}}, carry_i};
      check_value("{carry_o, sum_o}", 32'(exp_add), 32'({carry_o, sum_o}));
      exp_cmp = '0;
      if (cmp_a_i > cmp_b_i)
         exp_cmp.a_gt_b = 1'b1;
      else if (cmp_a_i < cmp_b_i)
         exp_cmp.a_lt_b = 1'b1;
      else if (cascade_i.a_eq_b)
         exp_cmp.a_eq_b = 1'b1;
      else
      begin
         // ls85 truth table rows for equal operands
         case ({cascade_i.a_gt_b, cascade_i.a_lt_b})
            2'b00:   exp_cmp = '{a_lt_b: 1'b1, a_eq_b: 1'b0, a_gt_b: 1'b1};
            2'b01:   exp_cmp.a_lt_b = 1'b1;
            2'b10:   exp_cmp.a_gt_b = 1'b1;
            default: exp_cmp = '0;
         endcase
      end
      check_value("cmp_o", 32'(exp_cmp), 32'(cmp_o));
      exp_prio = '1;
      found = 1'b0;
      if (!prio_ei_n_i)
      begin
         for (int i = BYTE_W - 1; i >= 0; i--)
         begin
            if (!found && !prio_req_n_i[i])
            begin
               found = 1'b1;
               exp_prio.code_n = ~SEL3_W'(i);
            end
         end
         exp_prio.gs_n = ~found;
         exp_prio.eo_n = found;
      end
      check_value("prio_o", 32'(exp_prio), 32'(prio_o));
      // pulse spacing and pixel clock edges
      if (pix6_cen_o)
      begin
         check_true(pix6_hist == 2'b01, "pixel enable without a rising edge of pix6_o before it");
         if (seen_pulse)
            check_true(cyc - last_pulse == PIX6_PERIOD,
                       $sformatf("pixel enable pulses are %0d cycles apart instead of %0d",
                                 cyc - last_pulse, PIX6_PERIOD));
         seen_pulse = 1'b1;
         last_pulse = cyc;
      end
      pix6_hist = {pix6_hist[0], pix6_o};
      if (pix12_o != pix12_prev)
      begin
         if (seen_toggle)
            check_true(cyc - last_toggle == 2,
                       $sformatf("pix12_o toggled after %0d cycles instead of 2",
                                 cyc - last_toggle));
         seen_toggle = 1'b1;
         last_toggle = cyc;
      end
      pix12_prev = pix12_o;
   endtask

   task automatic step_cycle();
      @(posedge clk);
      update_model();
      drive_random();
      cyc++;
      @(negedge clk);
      check_outputs();
   endtask

   // ==================================================
   // main sequence
   // ==================================================
   initial
   begin
      CR           = 1'b0;
      shift_ctrl_i = '0;
      dec8_i       = '0;
      dec4_i       = '0;
      add_a_i      = '0;
      add_b_i      = '0;
      carry_i      = 1'b0;
      cmp_a_i      = '0;
      cmp_b_i      = '0;
      cascade_i    = '0;
      prio_req_n_i = '1;
      prio_ei_n_i  = 1'b1;
      lfsr         = 16'd33145;
      cnt_m        = '0;
      q_m          = 1'b0;
      cen_m        = 1'b0;
      pix_m        = '0;
      pix6_hist    = 2'b00;
      pix12_prev   = 1'b0;
      seen_pulse   = 1'b0;
      seen_toggle  = 1'b0;
      got_pulse    = 1'b0;
      last_pulse   = 0;
      last_toggle  = 0;
      cyc          = 0;
      value_errs   = 0;
      other_errs   = 0;
      repeat (9) @(posedge clk);
      @(negedge clk);
      check_value("pix6_cen_o", 32'd0, 32'(pix6_cen_o));
      check_value("pixel_o", 32'd0, 32'(pixel_o));
      @(posedge clk);
      CR <= 1'b1;
      // bounded wait for the first enable pulse
      for (int i = 0; i < PULSE_TIMEOUT && !got_pulse; i++)
      begin
         step_cycle();
         got_pulse = pix6_cen_o;
      end
      check_true(got_pulse, "timed out waiting for the first pixel enable pulse");
      if (got_pulse)
      begin
         repeat (NUM_CYCLES) step_cycle();
      end
      $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      if (value_errs + other_errs == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
design/sf_clock_pkg.sv
design/sf_logic_pkg.sv
design/sf_clock_enable.sv
design/sf_pixel_shifter.sv
design/sf_select_decoder.sv
design/sf_position_unit.sv
design/sf_priority_encoder.sv
design/sf_logic_top.sv
test/tb_sf_logic_top.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run the testbench, decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -f src.f --top-module tb_sf_logic_top -Mdir obj_dir -o tb_sim \
   && ./obj_dir/tb_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
